//--- Makefile
TOP = tb_csr_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f vlog.f

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/csr_unit_sva.sv
`timescale 1ns/1ps

module csr_unit_sva (
  input logic                     clk_i,
  input logic                     rst_n_i,
  input logic [31:0]              crmd_i,
  input csr_types_pkg::excp_evt_t evt_i,
  input logic                     ertn_i,
  input logic                     m1_int_i
);

  // entry clears IE, so no request right after it
  a_int_masked_on_entry: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    evt_i.valid |=> !m1_int_i)
    else $error("interrupt request high right after exception entry");

  // exception entry drops to kernel level
  a_excp_plv: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    evt_i.valid |=> (crmd_i[csr_addr_pkg::CRMD_PLV_HI:csr_addr_pkg::CRMD_PLV_LO] == 2'b00))
    else $error("crmd PLV not zero after exception entry");

  a_excp_ertn_apart: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(evt_i.valid && ertn_i))
    else $error("exception event and ertn in the same cycle");

endmodule

bind csr_regfile csr_unit_sva u_csr_unit_sva (
  .clk_i    (clk),
  .rst_n_i  (rst_n),
  .crmd_i   (crmd_q),
  .evt_i    (evt_i),
  .ertn_i   (ertn_i),
  .m1_int_i (m1_int_o)
);

//--- bench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // release on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

//--- bench/tb_csr_unit.sv
`timescale 1ns/1ps

module tb_csr_unit;

  localparam int RESET_CYCLES = 20;
  localparam int MASK_CYCLES  = 60;
  localparam int EXCP_CYCLES  = 80;
  localparam int TIMER_CYCLES = 50;
  localparam int CNT_CYCLES   = 20;
  localparam int HWI_CYCLES   = 20;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + MASK_CYCLES + EXCP_CYCLES +
                                   TIMER_CYCLES + CNT_CYCLES + HWI_CYCLES + 100;
  localparam int TIMER_INITVAL = 5;
  localparam int CNT_GAP       = 7;

  logic                       clk;
  logic                       rst_n;
  csr_types_pkg::csr_wr_t     csr_wr_i;
  logic                       stall_i;
  csr_types_pkg::excp_flags_t excp_i;
  logic                       ertn_i;
  logic [31:0]                pc_i;
  logic [7:0]                 int_i;
  logic [13:0]                csr_r_addr_i;
  logic [1:0]                 rdcnt_i;
  logic [31:0]                csr_r_data_o;
  logic                       m1_int_o;
  logic [31:0]                lfsr;

  tb_clkgen #(.PERIOD_NS(10), .RESET_CYCLES(5)) u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

  csr_unit #(.SAVE_NUM(4)) u_csr_unit (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_wr_i     (csr_wr_i),
    .stall_i      (stall_i),
    .excp_i       (excp_i),
    .ertn_i       (ertn_i),
    .pc_i         (pc_i),
    .int_i        (int_i),
    .csr_r_addr_i (csr_r_addr_i),
    .rdcnt_i      (rdcnt_i),
    .csr_r_data_o (csr_r_data_o),
    .m1_int_o     (m1_int_o)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic rand_word(output logic [31:0] w);
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_next(lfsr);
      w[i] = lfsr[0];
    end
  endtask

  function automatic logic [31:0] merge_bits(input logic [31:0] old, input logic [31:0] data,
                                             input logic [31:0] mask, input logic [31:0] wmask);
    return (old & ~(mask & wmask)) | (data & mask & wmask);
  endfunction

  // {esubcode, ecode} of the highest-priority flag
  function automatic logic [14:0] expect_event(input logic [7:0] f);
    if (f[7]) return {9'd0, 6'h0};
    else if (f[6]) return {9'd0, 6'h8};
    else if (f[5]) return {9'd1, 6'h8};
    else if (f[4]) return {9'd0, 6'h9};
    else if (f[3]) return {9'd0, 6'hb};
    else if (f[2]) return {9'd0, 6'hc};
    else if (f[1]) return {9'd0, 6'hd};
    else return {9'd0, 6'he};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
      $display("Done: errors found");
      $fatal(1, "stopped at first error");
    end
  endtask

  task automatic write_csr(input logic [13:0] addr, input logic [31:0] mask,
                           input logic [31:0] data);
    csr_wr_i.we   = 1'b1;
    csr_wr_i.addr = addr;
    csr_wr_i.mask = mask;
    csr_wr_i.data = data;
    @(posedge clk);
    @(negedge clk);
    csr_wr_i.we = 1'b0;
  endtask

  task automatic read_csr(input logic [13:0] addr, input logic [1:0] mode,
                          output logic [31:0] data);
    csr_r_addr_i = addr;
    rdcnt_i      = mode;
    @(posedge clk);
    @(negedge clk);
    data    = csr_r_data_o;
    rdcnt_i = csr_addr_pkg::RDCNT_NONE;
  endtask

  task automatic check_reg(input string name, input logic [13:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    read_csr(addr, csr_addr_pkg::RDCNT_NONE, rd);
    check_value(name, rd, exp);
  endtask

  task automatic test_reset();
    logic [13:0] addrs [13];
    addrs = '{csr_addr_pkg::CSR_PRMD, csr_addr_pkg::CSR_ECTL, csr_addr_pkg::CSR_ESTAT,
              csr_addr_pkg::CSR_ERA, csr_addr_pkg::CSR_EENTRY, csr_addr_pkg::CSR_TID,
              csr_addr_pkg::CSR_SAVE0, csr_addr_pkg::CSR_SAVE0 + 14'd1,
              csr_addr_pkg::CSR_SAVE0 + 14'd2, csr_addr_pkg::CSR_SAVE0 + 14'd3,
              csr_addr_pkg::CSR_TCFG, csr_addr_pkg::CSR_TVAL, csr_addr_pkg::CSR_TICLR};
    check_reg("crmd", csr_addr_pkg::CSR_CRMD, csr_addr_pkg::CRMD_RESET);
    for (int i = 0; i < 13; i++) begin
      check_reg($sformatf("reg_%0h", addrs[i]), addrs[i], 32'd0);
    end
    check_value("m1_int_o", {31'd0, m1_int_o}, 32'd0);
  endtask

  task automatic test_masked_write();
    logic [13:0] addrs [6];
    logic [31:0] wmasks [6];
    logic [31:0] expv [6];
    logic [31:0] data;
    logic [31:0] mask;
    addrs  = '{csr_addr_pkg::CSR_SAVE0, csr_addr_pkg::CSR_SAVE0 + 14'd1,
               csr_addr_pkg::CSR_SAVE0 + 14'd2, csr_addr_pkg::CSR_SAVE0 + 14'd3,
               csr_addr_pkg::CSR_EENTRY, csr_addr_pkg::CSR_ECTL};
    wmasks = '{32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_ffff,
               csr_addr_pkg::EENTRY_WMASK, csr_addr_pkg::ECTL_WMASK};
    expv   = '{32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0};
    for (int r = 0; r < 4; r++) begin
      for (int i = 0; i < 6; i++) begin
        rand_word(data);
        rand_word(mask);
        write_csr(addrs[i], mask, data);
        expv[i] = merge_bits(expv[i], data, mask, wmasks[i]);
        check_reg($sformatf("reg_%0h", addrs[i]), addrs[i], expv[i]);
      end
    end
    // stalled write is dropped
    stall_i = 1'b1;
    write_csr(addrs[0], 32'hffff_ffff, ~expv[0]);
    stall_i = 1'b0;
    check_reg("save0_stalled", addrs[0], expv[0]);
  endtask

  task automatic test_exception();
    logic [7:0]  sets [5];
    logic [31:0] w;
    logic [31:0] pc;
    logic [31:0] crmd_val;
    logic [14:0] evt;
    sets = '{8'b0010_1010, 8'b0000_0101, 8'b1100_0000, 8'b0001_0011, 8'b0000_0001};
    for (int i = 0; i < 5; i++) begin
      rand_word(w);
      crmd_val = 32'h8 | {29'd0, w[2], w[1:0]};
      write_csr(csr_addr_pkg::CSR_CRMD, 32'hffff_ffff, crmd_val);
      rand_word(pc);
      excp_i = csr_types_pkg::excp_flags_t'(sets[i]);
      pc_i   = pc;
      @(posedge clk);
      @(negedge clk);
      excp_i = '0;
      evt    = expect_event(sets[i]);
      check_reg("estat", csr_addr_pkg::CSR_ESTAT, {1'b0, evt, 16'h0});
      check_reg("era", csr_addr_pkg::CSR_ERA, pc);
      check_reg("prmd", csr_addr_pkg::CSR_PRMD, {29'd0, w[2], w[1:0]});
      check_reg("crmd_excp", csr_addr_pkg::CSR_CRMD, 32'h8);
      ertn_i = 1'b1;
      @(posedge clk);
      @(negedge clk);
      ertn_i = 1'b0;
      check_reg("crmd_ertn", csr_addr_pkg::CSR_CRMD, crmd_val);
    end
  endtask

  task automatic test_timer();
    logic [31:0] rd;
    int          n;
    int          elapsed;
    n = TIMER_INITVAL * 4;
    write_csr(csr_addr_pkg::CSR_ECTL, 32'hffff_ffff, 32'h800);
    write_csr(csr_addr_pkg::CSR_CRMD, 32'hffff_ffff, 32'hc);
    write_csr(csr_addr_pkg::CSR_TCFG, 32'hffff_ffff, 32'((TIMER_INITVAL << 2) | 1));
    elapsed = 0;
    for (int j = 0; j < 3; j++) begin
      read_csr(csr_addr_pkg::CSR_TVAL, csr_addr_pkg::RDCNT_NONE, rd);
      check_value("tval", rd, 32'(n - elapsed));
      elapsed++;
    end
    while (!m1_int_o && elapsed < n + 8) begin
      @(posedge clk);
      @(negedge clk);
      elapsed++;
    end
    check_value("timer_int_edges", 32'(elapsed), 32'(n + 1));
    read_csr(csr_addr_pkg::CSR_ESTAT, csr_addr_pkg::RDCNT_NONE, rd);
    check_value("estat_ti", rd & 32'h800, 32'h800);
    // one-shot mode stops the timer
    check_reg("tval_done", csr_addr_pkg::CSR_TVAL, 32'hffff_ffff);
    check_reg("tcfg_done", csr_addr_pkg::CSR_TCFG, 32'(TIMER_INITVAL << 2));
    write_csr(csr_addr_pkg::CSR_TICLR, 32'h1, 32'h1);
    check_value("m1_int_o", {31'd0, m1_int_o}, 32'd0);
    read_csr(csr_addr_pkg::CSR_ESTAT, csr_addr_pkg::RDCNT_NONE, rd);
    check_value("estat_ti_clr", rd & 32'h800, 32'd0);
  endtask

  task automatic test_counters();
    logic [31:0] tid;
    logic [31:0] v1;
    logic [31:0] v2;
    logic [31:0] rd;
    rand_word(tid);
    write_csr(csr_addr_pkg::CSR_TID, 32'hffff_ffff, tid);
    read_csr(csr_addr_pkg::CSR_CRMD, csr_addr_pkg::RDCNT_ID, rd);
    check_value("rdcnt_id", rd, tid);
    read_csr(csr_addr_pkg::CSR_CRMD, csr_addr_pkg::RDCNT_VLOW, v1);
    repeat (CNT_GAP - 1) @(negedge clk);
    read_csr(csr_addr_pkg::CSR_CRMD, csr_addr_pkg::RDCNT_VLOW, v2);
    check_value("rdcnt_vlow_delta", v2 - v1, 32'(CNT_GAP));
    read_csr(csr_addr_pkg::CSR_CRMD, csr_addr_pkg::RDCNT_VHIGH, rd);
    check_value("rdcnt_vhigh", rd, 32'd0);
  endtask

  task automatic test_hw_int();
    logic [31:0] w;
    logic [31:0] rd;
    logic [7:0]  lines;
    rand_word(w);
    lines = w[7:0] | 8'h01;
    write_csr(csr_addr_pkg::CSR_ECTL, 32'hffff_ffff, 32'h3fc);
    int_i = lines;
    // sampling stage, then estat
    @(posedge clk);
    @(negedge clk);
    check_value("m1_int_o_early", {31'd0, m1_int_o}, 32'd0);
    @(posedge clk);
    @(negedge clk);
    check_value("m1_int_o", {31'd0, m1_int_o}, 32'd1);
    read_csr(csr_addr_pkg::CSR_ESTAT, csr_addr_pkg::RDCNT_NONE, rd);
    check_value("estat_hwi", rd & 32'h3fc, {22'd0, lines, 2'b00});
    int_i = 8'd0;
    repeat (2) @(negedge clk);
    check_value("m1_int_o_off", {31'd0, m1_int_o}, 32'd0);
  endtask

  initial begin
    lfsr         = 32'h89e0;
    csr_wr_i     = '0;
    stall_i      = 1'b0;
    excp_i       = '0;
    ertn_i       = 1'b0;
    pc_i         = 32'd0;
    int_i        = 8'd0;
    csr_r_addr_i = 14'd0;
    rdcnt_i      = csr_addr_pkg::RDCNT_NONE;
    wait (rst_n === 1'b1);
    @(negedge clk);
    test_reset();
    test_masked_write();
    test_exception();
    test_timer();
    test_counters();
    test_hw_int();
    $display("Done: no errors");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

endmodule

//--- design/csr_addr_pkg.sv
package csr_addr_pkg;

  // register addresses
  localparam logic [13:0] CSR_CRMD   = 14'h0;
  localparam logic [13:0] CSR_PRMD   = 14'h1;
  localparam logic [13:0] CSR_ECTL   = 14'h4;
  localparam logic [13:0] CSR_ESTAT  = 14'h5;
  localparam logic [13:0] CSR_ERA    = 14'h6;
  localparam logic [13:0] CSR_EENTRY = 14'hc;
  // save registers sit at consecutive addresses from here
  localparam logic [13:0] CSR_SAVE0  = 14'h30;
  localparam logic [13:0] CSR_TID    = 14'h40;
  localparam logic [13:0] CSR_TCFG   = 14'h41;
  localparam logic [13:0] CSR_TVAL   = 14'h42;
  localparam logic [13:0] CSR_TICLR  = 14'h44;

  // field positions
  localparam int CRMD_PLV_LO     = 0;
  localparam int CRMD_PLV_HI     = 1;
  localparam int CRMD_IE         = 2;
  localparam int CRMD_DA         = 3;
  localparam int CRMD_DATM_HI    = 8;
  localparam int PRMD_PPLV_LO    = 0;
  localparam int PRMD_PPLV_HI    = 1;
  localparam int PRMD_PIE        = 2;
  localparam int ESTAT_SWI_HI    = 1;
  localparam int ESTAT_HWI_LO    = 2;
  localparam int ESTAT_HWI_HI    = 9;
  localparam int ESTAT_TI        = 11;
  localparam int ESTAT_ECODE_LO  = 16;
  localparam int ESTAT_ECODE_HI  = 21;
  localparam int ESTAT_ESUB_LO   = 22;
  localparam int ESTAT_ESUB_HI   = 30;
  localparam int EENTRY_VA_LO    = 6;
  localparam int TCFG_EN         = 0;
  localparam int TCFG_PERIODIC   = 1;
  localparam int TCFG_INITVAL_LO = 2;
  localparam int TICLR_CLR       = 0;

  // out of reset only DA is set
  localparam logic [31:0] CRMD_RESET = 32'd1 << CRMD_DA;

  // writable bits per register
  localparam logic [31:0] CRMD_WMASK   = (32'd1 << (CRMD_DATM_HI + 1)) - 32'd1;
  localparam logic [31:0] PRMD_WMASK   = (32'd1 << (PRMD_PIE + 1)) - 32'd1;
  localparam logic [31:0] ECTL_WMASK   = 32'h0000_1bff;
  localparam logic [31:0] ESTAT_WMASK  = (32'd1 << (ESTAT_SWI_HI + 1)) - 32'd1;
  localparam logic [31:0] EENTRY_WMASK = 32'hffff_ffff << EENTRY_VA_LO;
  localparam logic [31:0] TCFG_INITVAL_MASK = 32'hffff_ffff << TCFG_INITVAL_LO;

  // rdcnt forms
  localparam logic [1:0] RDCNT_NONE  = 2'd0;
  localparam logic [1:0] RDCNT_ID    = 2'd1;
  localparam logic [1:0] RDCNT_VLOW  = 2'd2;
  localparam logic [1:0] RDCNT_VHIGH = 2'd3;

endpackage

//--- design/csr_event_decode.sv
`timescale 1ns/1ps

module csr_event_decode (
  input  logic                       clk,
  input  logic                       rst_n,
  input  csr_types_pkg::csr_wr_t     csr_wr_i,
  input  logic                       stall_i,
  input  csr_types_pkg::excp_flags_t excp_i,
  input  logic                       ertn_i,
  output csr_types_pkg::csr_wr_t     wr_o,
  output csr_types_pkg::excp_evt_t   evt_o,
  output logic                       ertn_o
);

  logic ertn_q;

  // stalled writes are dropped
  always_comb begin
    wr_o    = csr_wr_i;
    wr_o.we = csr_wr_i.we && !stall_i;
  end

  always_comb begin
    evt_o       = '0;
    evt_o.valid = |excp_i;
    if (excp_i.intr) begin
      evt_o.ecode = 6'h0;
    end else if (excp_i.adef) begin
      evt_o.ecode = 6'h8;
    end else if (excp_i.adem) begin
      evt_o.ecode    = 6'h8;
      evt_o.esubcode = 9'd1;
    end else if (excp_i.ale) begin
      evt_o.ecode = 6'h9;
    end else if (excp_i.sys) begin
      evt_o.ecode = 6'hb;
    end else if (excp_i.brk) begin
      evt_o.ecode = 6'hc;
    end else if (excp_i.ine) begin
      evt_o.ecode = 6'hd;
    end else if (excp_i.ipe) begin
      evt_o.ecode = 6'he;
    end
  end

  // ertn acts once per pulse, a held level does not repeat it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ertn_q <= 1'b0;
    end else begin
      ertn_q <= ertn_i;
    end
  end

  assign ertn_o = ertn_i && !ertn_q;

endmodule

//--- design/csr_read_port.sv
`timescale 1ns/1ps

module csr_read_port #(
  parameter int SAVE_NUM = 4
) (
  input  logic                        clk,
  input  logic [13:0]                 csr_r_addr_i,
  input  logic [1:0]                  rdcnt_i,
  input  csr_types_pkg::csr_arch_t    arch_i,
  input  csr_types_pkg::timer_state_t timer_i,
  output logic [31:0]                 csr_r_data_o
);

  logic [31:0] rdata;

  always_comb begin
    rdata = '0;
    case (rdcnt_i)
      csr_addr_pkg::RDCNT_ID:    rdata = arch_i.tid;
      csr_addr_pkg::RDCNT_VLOW:  rdata = timer_i.cnt[31:0];
      csr_addr_pkg::RDCNT_VHIGH: rdata = timer_i.cnt[63:32];
      csr_addr_pkg::RDCNT_NONE: begin
        case (csr_r_addr_i)
          csr_addr_pkg::CSR_CRMD:   rdata = arch_i.crmd;
          csr_addr_pkg::CSR_PRMD:   rdata = arch_i.prmd;
          csr_addr_pkg::CSR_ECTL:   rdata = arch_i.ectl;
          csr_addr_pkg::CSR_ESTAT:  rdata = arch_i.estat;
          csr_addr_pkg::CSR_ERA:    rdata = arch_i.era;
          csr_addr_pkg::CSR_EENTRY: rdata = arch_i.eentry;
          csr_addr_pkg::CSR_TID:    rdata = arch_i.tid;
          csr_addr_pkg::CSR_TCFG:   rdata = timer_i.tcfg;
          csr_addr_pkg::CSR_TVAL:   rdata = timer_i.tval;
          // write-only clear register
          csr_addr_pkg::CSR_TICLR:  rdata = '0;
          default:                  rdata = '0;
        endcase
        // only implemented save slots answer
        for (int i = 0; i < SAVE_NUM; i++) begin
          if (csr_r_addr_i == csr_addr_pkg::CSR_SAVE0 + 14'(i)) begin
            rdata = arch_i.save[i];
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    csr_r_data_o <= rdata;
  end

endmodule

//--- design/csr_regfile.sv
`timescale 1ns/1ps

module csr_regfile #(
  parameter int SAVE_NUM = 4
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  csr_types_pkg::csr_wr_t   wr_i,
  input  csr_types_pkg::excp_evt_t evt_i,
  input  logic                     ertn_i,
  input  logic [31:0]              pc_i,
  input  logic [7:0]               int_i,
  input  logic                     ti_i,
  output csr_types_pkg::csr_arch_t arch_o,
  output logic                     m1_int_o
);

  logic [31:0] crmd_q;
  logic [31:0] prmd_q;
  logic [31:0] ectl_q;
  logic [31:0] era_q;
  logic [31:0] eentry_q;
  logic [31:0] tid_q;
  logic [1:0]  is_sw_q;
  logic [7:0]  int_q;
  logic [7:0]  is_hw_q;
  logic [5:0]  ecode_q;
  logic [8:0]  esubcode_q;
  logic [31:0] estat_w;
  logic [31:0] estat_wdata;
  logic [31:0] save_w [csr_types_pkg::SAVE_MAX];
  logic        crmd_we;
  logic        prmd_we;
  logic        ectl_we;
  logic        estat_we;
  logic        era_we;
  logic        eentry_we;
  logic        tid_we;

  assign crmd_we   = wr_i.we && (wr_i.addr == csr_addr_pkg::CSR_CRMD);
  assign prmd_we   = wr_i.we && (wr_i.addr == csr_addr_pkg::CSR_PRMD);
  assign ectl_we   = wr_i.we && (wr_i.addr == csr_addr_pkg::CSR_ECTL);
  assign estat_we  = wr_i.we && (wr_i.addr == csr_addr_pkg::CSR_ESTAT);
  assign era_we    = wr_i.we && (wr_i.addr == csr_addr_pkg::CSR_ERA);
  assign eentry_we = wr_i.we && (wr_i.addr == csr_addr_pkg::CSR_EENTRY);
  assign tid_we    = wr_i.we && (wr_i.addr == csr_addr_pkg::CSR_TID);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      crmd_q <= csr_addr_pkg::CRMD_RESET;
    end else if (crmd_we) begin
      crmd_q <= csr_types_pkg::wr_merge(wr_i, crmd_q, csr_addr_pkg::CRMD_WMASK);
    end else if (evt_i.valid) begin
      crmd_q[csr_addr_pkg::CRMD_PLV_HI:csr_addr_pkg::CRMD_PLV_LO] <= 2'b00;
      crmd_q[csr_addr_pkg::CRMD_IE] <= 1'b0;
    end else if (ertn_i) begin
      crmd_q[csr_addr_pkg::CRMD_PLV_HI:csr_addr_pkg::CRMD_PLV_LO] <=
        prmd_q[csr_addr_pkg::PRMD_PPLV_HI:csr_addr_pkg::PRMD_PPLV_LO];
      crmd_q[csr_addr_pkg::CRMD_IE] <= prmd_q[csr_addr_pkg::PRMD_PIE];
    end
  end

  // previous mode saved on entry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prmd_q <= '0;
    end else if (prmd_we) begin
      prmd_q <= csr_types_pkg::wr_merge(wr_i, prmd_q, csr_addr_pkg::PRMD_WMASK);
    end else if (evt_i.valid) begin
      prmd_q[csr_addr_pkg::PRMD_PPLV_HI:csr_addr_pkg::PRMD_PPLV_LO] <=
        crmd_q[csr_addr_pkg::CRMD_PLV_HI:csr_addr_pkg::CRMD_PLV_LO];
      prmd_q[csr_addr_pkg::PRMD_PIE] <= crmd_q[csr_addr_pkg::CRMD_IE];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      era_q <= '0;
    end else if (era_we) begin
      era_q <= csr_types_pkg::wr_merge(wr_i, era_q, '1);
    end else if (evt_i.valid) begin
      era_q <= pc_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ectl_q   <= '0;
      eentry_q <= '0;
      tid_q    <= '0;
    end else begin
      if (ectl_we) begin
        ectl_q <= csr_types_pkg::wr_merge(wr_i, ectl_q, csr_addr_pkg::ECTL_WMASK);
      end
      if (eentry_we) begin
        eentry_q <= csr_types_pkg::wr_merge(wr_i, eentry_q, csr_addr_pkg::EENTRY_WMASK);
      end
      if (tid_we) begin
        tid_q <= csr_types_pkg::wr_merge(wr_i, tid_q, '1);
      end
    end
  end

  // estat pieces, hw lines pass a sync stage first
  assign estat_wdata = csr_types_pkg::wr_merge(wr_i, estat_w, csr_addr_pkg::ESTAT_WMASK);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      is_sw_q    <= '0;
      int_q      <= '0;
      is_hw_q    <= '0;
      ecode_q    <= '0;
      esubcode_q <= '0;
    end else begin
      int_q   <= int_i;
      is_hw_q <= int_q;
      if (estat_we) begin
        is_sw_q <= estat_wdata[csr_addr_pkg::ESTAT_SWI_HI:0];
      end
      if (evt_i.valid) begin
        ecode_q    <= evt_i.ecode;
        esubcode_q <= evt_i.esubcode;
      end
    end
  end

  always_comb begin
    estat_w = '0;
    estat_w[csr_addr_pkg::ESTAT_SWI_HI:0] = is_sw_q;
    estat_w[csr_addr_pkg::ESTAT_HWI_HI:csr_addr_pkg::ESTAT_HWI_LO] = is_hw_q;
    estat_w[csr_addr_pkg::ESTAT_TI] = ti_i;
    estat_w[csr_addr_pkg::ESTAT_ECODE_HI:csr_addr_pkg::ESTAT_ECODE_LO] = ecode_q;
    estat_w[csr_addr_pkg::ESTAT_ESUB_HI:csr_addr_pkg::ESTAT_ESUB_LO] = esubcode_q;
  end

  for (genvar i = 0; i < csr_types_pkg::SAVE_MAX; i++) begin : g_save
    if (i < SAVE_NUM) begin : g_reg
      logic [31:0] save_q;
      logic        save_we;

      assign save_we = wr_i.we && (wr_i.addr == csr_addr_pkg::CSR_SAVE0 + 14'(i));

      always_ff @(posedge clk) begin
        if (!rst_n) begin
          save_q <= '0;
        end else if (save_we) begin
          save_q <= csr_types_pkg::wr_merge(wr_i, save_q, '1);
        end
      end

      assign save_w[i] = save_q;
    end else begin : g_absent
      assign save_w[i] = '0;
    end
  end

  always_comb begin
    arch_o        = '0;
    arch_o.crmd   = crmd_q;
    arch_o.prmd   = prmd_q;
    arch_o.ectl   = ectl_q;
    arch_o.estat  = estat_w;
    arch_o.era    = era_q;
    arch_o.eentry = eentry_q;
    arch_o.tid    = tid_q;
    for (int i = 0; i < csr_types_pkg::SAVE_MAX; i++) begin
      arch_o.save[i] = save_w[i];
    end
  end

  // estat bit 10 is always zero, so bits 11:0 cover 11 and 9:0
  assign m1_int_o = crmd_q[csr_addr_pkg::CRMD_IE] &&
                    |(estat_w[csr_addr_pkg::ESTAT_TI:0] & ectl_q[csr_addr_pkg::ESTAT_TI:0]);

endmodule

//--- design/csr_timer.sv
`timescale 1ns/1ps

module csr_timer (
  input  logic                        clk,
  input  logic                        rst_n,
  input  csr_types_pkg::csr_wr_t      wr_i,
  output logic                        ti_o,
  output csr_types_pkg::timer_state_t timer_o
);

  logic [31:0] tcfg_q;
  logic [31:0] tval_q;
  logic [31:0] tcfg_next;
  logic [63:0] cnt_q;
  logic        ti_q;
  logic        tcfg_we;
  logic        ticlr_clr;
  logic        expire;

  assign tcfg_we   = wr_i.we && (wr_i.addr == csr_addr_pkg::CSR_TCFG);
  assign tcfg_next = csr_types_pkg::wr_merge(wr_i, tcfg_q, '1);
  assign ticlr_clr = wr_i.we && (wr_i.addr == csr_addr_pkg::CSR_TICLR) &&
                     wr_i.mask[csr_addr_pkg::TICLR_CLR] && wr_i.data[csr_addr_pkg::TICLR_CLR];
  assign expire    = tcfg_q[csr_addr_pkg::TCFG_EN] && (tval_q == 32'd0);

  // tval counts from initval * 4 down to zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tcfg_q <= '0;
      tval_q <= '0;
    end else if (tcfg_we) begin
      tcfg_q <= tcfg_next;
      tval_q <= tcfg_next & csr_addr_pkg::TCFG_INITVAL_MASK;
    end else if (expire) begin
      if (tcfg_q[csr_addr_pkg::TCFG_PERIODIC]) begin
        tval_q <= tcfg_q & csr_addr_pkg::TCFG_INITVAL_MASK;
      end else begin
        tcfg_q[csr_addr_pkg::TCFG_EN] <= 1'b0;
        tval_q <= '1;
      end
    end else if (tcfg_q[csr_addr_pkg::TCFG_EN]) begin
      tval_q <= tval_q - 32'd1;
    end
  end

  // clear wins over a same-cycle expiry
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ti_q <= 1'b0;
    end else if (ticlr_clr) begin
      ti_q <= 1'b0;
    end else if (expire) begin
      ti_q <= 1'b1;
    end
  end

  // stable counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 64'd1;
    end
  end

  assign ti_o    = ti_q;
  assign timer_o = '{tcfg: tcfg_q, tval: tval_q, cnt: cnt_q};

endmodule

//--- design/csr_types_pkg.sv
package csr_types_pkg;

  localparam int SAVE_MAX = 4;

  typedef struct packed {
    logic        we;
    logic [13:0] addr;
    logic [31:0] mask;
    logic [31:0] data;
  } csr_wr_t;

  // raw flags, intr has the highest priority
  typedef struct packed {
    logic intr;
    logic adef;
    logic adem;
    logic ale;
    logic sys;
    logic brk;
    logic ine;
    logic ipe;
  } excp_flags_t;

  typedef struct packed {
    logic       valid;
    logic [5:0] ecode;
    logic [8:0] esubcode;
  } excp_evt_t;

  typedef struct packed {
    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] ectl;
    logic [31:0] estat;
    logic [31:0] era;
    logic [31:0] eentry;
    logic [31:0] tid;
    logic [SAVE_MAX-1:0][31:0] save;
  } csr_arch_t;

  typedef struct packed {
    logic [31:0] tcfg;
    logic [31:0] tval;
    logic [63:0] cnt;
  } timer_state_t;

  // bits under both the request mask and the register's writable mask
  function automatic logic [31:0] wr_merge(input csr_wr_t wr, input logic [31:0] old,
                                           input logic [31:0] wmask);
    logic [31:0] m;
    m = wr.mask & wmask;
    return (old & ~m) | (wr.data & m);
  endfunction

endpackage

//--- design/csr_unit.sv
`timescale 1ns/1ps

module csr_unit #(
  parameter int SAVE_NUM = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  csr_types_pkg::csr_wr_t     csr_wr_i,
  input  logic                       stall_i,
  input  csr_types_pkg::excp_flags_t excp_i,
  input  logic                       ertn_i,
  input  logic [31:0]                pc_i,
  input  logic [7:0]                 int_i,
  input  logic [13:0]                csr_r_addr_i,
  input  logic [1:0]                 rdcnt_i,
  output logic [31:0]                csr_r_data_o,
  output logic                       m1_int_o
);

  csr_types_pkg::csr_wr_t      wr;
  csr_types_pkg::excp_evt_t    evt;
  csr_types_pkg::csr_arch_t    arch;
  csr_types_pkg::timer_state_t timer_state;
  logic                        ertn;
  logic                        ti;

  csr_event_decode u_event_decode (
    .clk      (clk),
    .rst_n    (rst_n),
    .csr_wr_i (csr_wr_i),
    .stall_i  (stall_i),
    .excp_i   (excp_i),
    .ertn_i   (ertn_i),
    .wr_o     (wr),
    .evt_o    (evt),
    .ertn_o   (ertn)
  );

  csr_regfile #(
    .SAVE_NUM (SAVE_NUM)
  ) u_regfile (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_i     (wr),
    .evt_i    (evt),
    .ertn_i   (ertn),
    .pc_i     (pc_i),
    .int_i    (int_i),
    .ti_i     (ti),
    .arch_o   (arch),
    .m1_int_o (m1_int_o)
  );

  csr_timer u_timer (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (wr),
    .ti_o    (ti),
    .timer_o (timer_state)
  );

  csr_read_port #(
    .SAVE_NUM (SAVE_NUM)
  ) u_read_port (
    .clk          (clk),
    .csr_r_addr_i (csr_r_addr_i),
    .rdcnt_i      (rdcnt_i),
    .arch_i       (arch),
    .timer_i      (timer_state),
    .csr_r_data_o (csr_r_data_o)
  );

endmodule

//--- vlog.f
design/csr_addr_pkg.sv
design/csr_types_pkg.sv
design/csr_event_decode.sv
design/csr_regfile.sv
design/csr_timer.sv
design/csr_read_port.sv
design/csr_unit.sv
bench/tb_clkgen.sv
bench/csr_unit_sva.sv
bench/tb_csr_unit.sv
